// ==== aw_capture.sv ====
/*
 * AW channel capture: handshake detection, budget computation
 * and the registered enqueue towards the slot table
 */
`timescale 1ns/1ns

`include "guard_consts.svh"

module aw_capture
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      aw_valid_i,
  input  logic      aw_ready_i,
  input  aw_meta_t  aw_meta_i,
  input  budget_t   budget_factor_i,
  input  cnt_t      load_i,
  enq_if.src        enq
);

  logic     aw_hs;
  cnt_t     factor;
  cnt_t     own_load;
  cnt_t     budget;
  logic     enq_valid_q;
  aw_meta_t enq_meta_q;
  cnt_t     enq_budget_q;

  assign aw_hs  = aw_valid_i & aw_ready_i;
  assign factor = cnt_t'(budget_factor_i);

  // Prescaled beats of this burst
  assign own_load = cnt_t'((cnt_t'(aw_meta_i.len) + cnt_t'(1)) / `GUARD_PRESC_DIV);

  // Scaled backlog plus own bursts, plus one tick so the budget is never zero
  assign budget = cnt_t'(factor * load_i + factor * own_load + cnt_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enq_valid_q <= 1'b0;
    end else begin
      enq_valid_q <= aw_hs;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      enq_meta_q   <= aw_meta_i;
      enq_budget_q <= budget;
    end
  end

  assign enq.valid  = enq_valid_q;
  assign enq.meta   = enq_meta_q;
  assign enq.budget = enq_budget_q;

endmodule

// ==== fault_reporter.sv ====
/*
 * Fault latch: reset request, interrupt, fault flags and details,
 * and the remaining budget of the last retired write
 */
`timescale 1ns/1ns

module fault_reporter
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  evt_if.dst    evt,
  input  logic  reset_clear_i,
  output logic  flush_o,
  output logic  reset_req_o,
  output logic  irq_o,
  output logic  timeout_o,
  output logic  unwanted_o,
  output addr_t irq_addr_o,
  output id_t   irq_id_o,
  output cnt_t  latency_o
);

  // A new fault wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_req_o <= 1'b0;
      irq_o       <= 1'b0;
      timeout_o   <= 1'b0;
      unwanted_o  <= 1'b0;
      irq_addr_o  <= '0;
      irq_id_o    <= '0;
    end else if (evt.fault_valid) begin
      reset_req_o <= 1'b1;
      irq_o       <= 1'b1;
      timeout_o   <= timeout_o | (evt.fault_kind == FAULT_TIMEOUT);
      unwanted_o  <= unwanted_o | (evt.fault_kind == FAULT_UNWANTED);
      irq_addr_o  <= evt.fault_meta.addr;
      irq_id_o    <= evt.fault_meta.id;
    end else if (reset_clear_i) begin
      reset_req_o <= 1'b0;
      irq_o       <= 1'b0;
      timeout_o   <= 1'b0;
      unwanted_o  <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latency_o <= '0;
    end else if (evt.retire_valid) begin
      latency_o <= evt.retire_cnt;
    end
  end

  // Table stays empty for as long as the reset request is pending
  assign flush_o = reset_req_o;

endmodule

// ==== filelist.f ====
+incdir+.
guard_axi_pkg.sv
guard_cfg_pkg.sv
guard_ifs.sv
aw_capture.sv
tick_gen.sv
txn_table.sv
fault_reporter.sv
write_guard.sv
tb_clk_gen.sv
tb_write_guard.sv

// ==== guard_axi_pkg.sv ====
/*
 * Types for the observed AXI4 write channels
 * (ID, address, burst length and the AW metadata record)
 */
package guard_axi_pkg;

  `include "guard_consts.svh"

  typedef logic [`GUARD_ID_W-1:0]   id_t;
  typedef logic [`GUARD_ADDR_W-1:0] addr_t;

  // AXI encoding, number of beats minus one
  typedef logic [`GUARD_LEN_W-1:0]  len_t;

  // Everything the guard keeps from one AW beat
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_meta_t;

endpackage

// ==== guard_cfg_pkg.sv ====
/*
 * Guard-internal types: budget counter, budget factor,
 * slot index, slot record and fault kind
 */
package guard_cfg_pkg;

  import guard_axi_pkg::*;

  `include "guard_consts.svh"

  typedef logic [`GUARD_CNT_W-1:0]            cnt_t;
  typedef logic [`GUARD_BUDGET_W-1:0]         budget_t;
  typedef logic [$clog2(`GUARD_MAX_TXNS)-1:0] slot_idx_t;

  // One outstanding write
  typedef struct packed {
    logic      valid;
    aw_meta_t  meta;
    cnt_t      cnt;
    slot_idx_t ahead;   // older same-ID writes still outstanding
  } slot_t;

  typedef enum logic [1:0] {
    FAULT_NONE     = 2'd0,
    FAULT_TIMEOUT  = 2'd1,
    FAULT_UNWANTED = 2'd2
  } fault_e;

endpackage

// ==== guard_consts.svh ====
/*
 * Global constants of the AXI4 write guard: bus field widths,
 * slot count, budget counter width and prescaler setting
 */
`ifndef GUARD_CONSTS_SVH
`define GUARD_CONSTS_SVH

`define GUARD_ID_W      4
`define GUARD_ADDR_W    32
`define GUARD_LEN_W     8
`define GUARD_MAX_TXNS  8
`define GUARD_CNT_W     16
`define GUARD_PRESC_DIV 4
`define GUARD_BUDGET_W  3

`endif

// ==== guard_ifs.sv ====
/*
 * Interfaces inside the write guard: enqueue of captured writes
 * and retire/fault events from the slot table
 */
`timescale 1ns/1ns

interface enq_if
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;
();

  logic     valid;
  aw_meta_t meta;
  cnt_t     budget;

  modport src (output valid, meta, budget);
  modport dst (input valid, meta, budget);

endinterface

interface evt_if
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;
();

  logic     retire_valid;
  cnt_t     retire_cnt;
  logic     fault_valid;
  fault_e   fault_kind;
  aw_meta_t fault_meta;

  modport src (output retire_valid, retire_cnt, fault_valid, fault_kind, fault_meta);
  modport dst (input retire_valid, retire_cnt, fault_valid, fault_kind, fault_meta);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Builds the write guard testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_write_guard -f filelist.f -o sim_tb \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -q "STATUS: PASS" && exit 0 || exit 1

// ==== tb_clk_gen.sv ====
/*
 * Testbench clock and power-on reset
 */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PeriodNs    = 8,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no <= 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #(PeriodNs / 2) clk_o = ~clk_o;

endmodule

// ==== tb_write_guard.sv ====
/*
 * Testbench for the AXI4 write guard: random writes and responses,
 * reference model of budgets and retire order, compare process, watchdog
 */
`timescale 1ns/1ns

`include "guard_consts.svh"

module tb_write_guard
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;
();

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 16;
  localparam int WriteCycles = 4;
  localparam int RespCycles  = 4;
  localparam int ClearCycles = 3;
  localparam int FaultWait   = 8;
  // Longest budget in the timeout test is five ticks
  localparam int TimeoutWait = 7 * `GUARD_PRESC_DIV + FaultWait;
  localparam int TestCycles  = 13 * (WriteCycles + RespCycles)
                             + RespCycles + FaultWait + ClearCycles
                             + WriteCycles + TimeoutWait
                             + ClearCycles + WriteCycles + RespCycles;
  localparam int WatchdogNs  = 2 * (ResetCycles + TestCycles) * ClkPeriod;

  localparam int ModeRetire = 0;
  localparam int ModeFault  = 1;
  localparam int ModeIdle   = 2;

  logic    clk;
  logic    rst_n;
  logic    aw_valid;
  logic    aw_ready;
  id_t     aw_id;
  addr_t   aw_addr;
  len_t    aw_len;
  logic    b_valid;
  logic    b_ready;
  id_t     b_id;
  budget_t budget_factor;
  logic    reset_clear;
  logic    reset_req;
  logic    irq;
  logic    timeout;
  logic    unwanted;
  addr_t   irq_addr;
  id_t     irq_id;
  cnt_t    latency;

  // Outstanding writes in issue order, with the budget each one got
  aw_meta_t out_meta[$];
  cnt_t     out_budget[$];

  int    exp_mode;
  logic  exp_timeout;
  logic  exp_unwanted;
  id_t   exp_id;
  addr_t exp_addr;
  cnt_t  exp_lo;
  cnt_t  exp_hi;
  int    checks = 0;
  int    errors = 0;
  int    tests = 0;
  int    failed_tests = 0;
  int    errors_at_start = 0;
  event  check_ev;

  tb_clk_gen #(.PeriodNs(ClkPeriod), .ResetCycles(ResetCycles)) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  write_guard i_write_guard (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .aw_valid_i      (aw_valid),
    .aw_ready_i      (aw_ready),
    .aw_id_i         (aw_id),
    .aw_addr_i       (aw_addr),
    .aw_len_i        (aw_len),
    .b_valid_i       (b_valid),
    .b_ready_i       (b_ready),
    .b_id_i          (b_id),
    .budget_factor_i (budget_factor),
    .reset_clear_i   (reset_clear),
    .reset_req_o     (reset_req),
    .irq_o           (irq),
    .timeout_o       (timeout),
    .unwanted_o      (unwanted),
    .irq_addr_o      (irq_addr),
    .irq_id_o        (irq_id),
    .latency_o       (latency)
  );

  // Budget in ticks: factor times backlog, plus factor times own beats, plus one
  function automatic cnt_t expected_budget(budget_t factor, cnt_t load, len_t len);
    int f;
    f = int'(factor);
    return cnt_t'(f * int'(load) + f * ((int'(len) + 1) / `GUARD_PRESC_DIV) + 1);
  endfunction

  function automatic cnt_t model_load();
    int sum;
    sum = 0;
    foreach (out_meta[i]) begin
      sum += (int'(out_meta[i].len) + 1) / `GUARD_PRESC_DIV + 1;
    end
    return cnt_t'(sum);
  endfunction

  // Same-ID writes retire oldest first, so the first match in issue order
  function automatic int oldest_index(id_t id);
    int idx;
    idx = -1;
    for (int i = out_meta.size() - 1; i >= 0; i--) begin
      if (out_meta[i].id == id) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic len_t long_len();
    return len_t'(63 + $urandom % 193);
  endfunction

  task automatic compare_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_id(string name, id_t got, id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_addr(string name, addr_t got, addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_cnt(string name, cnt_t got, cnt_t lo, cnt_t hi);
    checks++;
    if ($isunknown(got) || got < lo || got > hi) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h..0x%0h", name, got, lo, hi);
    end
  endtask

  initial begin : compare_proc
    forever begin
      @(check_ev);
      case (exp_mode)
        ModeRetire: begin
          compare_cnt("latency_o", latency, exp_lo, exp_hi);
          compare_bit("reset_req_o", reset_req, 1'b0);
          compare_bit("irq_o", irq, 1'b0);
        end
        ModeFault: begin
          compare_bit("reset_req_o", reset_req, 1'b1);
          compare_bit("irq_o", irq, 1'b1);
          compare_bit("timeout_o", timeout, exp_timeout);
          compare_bit("unwanted_o", unwanted, exp_unwanted);
          compare_id("irq_id_o", irq_id, exp_id);
          compare_addr("irq_addr_o", irq_addr, exp_addr);
        end
        default: begin
          compare_bit("reset_req_o", reset_req, 1'b0);
          compare_bit("irq_o", irq, 1'b0);
          compare_bit("timeout_o", timeout, 1'b0);
          compare_bit("unwanted_o", unwanted, 1'b0);
        end
      endcase
    end
  end

  task automatic fire_check();
    -> check_ev;
    #1;
  endtask

  task automatic wait_for_fault(int max_cycles);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < max_cycles) begin
      @(negedge clk);
      seen = reset_req;
      n++;
    end
    if (!seen) begin
      errors++;
      $display("reset_req_o did not rise within %0d cycles", max_cycles);
    end
  endtask

  // Enqueue is live two edges after the handshake
  task automatic issue_write(id_t id, addr_t addr, len_t len, budget_t factor);
    aw_meta_t meta;
    cnt_t     budget;
    budget    = expected_budget(factor, model_load(), len);
    meta.id   = id;
    meta.addr = addr;
    meta.len  = len;
    @(posedge clk);
    aw_valid      <= 1'b1;
    aw_ready      <= 1'b1;
    aw_id         <= id;
    aw_addr       <= addr;
    aw_len        <= len;
    budget_factor <= factor;
    @(posedge clk);
    aw_valid <= 1'b0;
    aw_ready <= 1'b0;
    repeat (2) @(posedge clk);
    out_meta.push_back(meta);
    out_budget.push_back(budget);
  endtask

  task automatic send_response(id_t id);
    int idx;
    idx = oldest_index(id);
    @(posedge clk);
    b_valid <= 1'b1;
    b_ready <= 1'b1;
    b_id    <= id;
    @(posedge clk);
    b_valid <= 1'b0;
    b_ready <= 1'b0;
    if (idx >= 0) begin
      @(posedge clk);
      @(negedge clk);
      exp_mode = ModeRetire;
      exp_lo   = cnt_t'(1);
      exp_hi   = out_budget[idx];
      out_meta.delete(idx);
      out_budget.delete(idx);
    end else begin
      wait_for_fault(FaultWait);
      exp_mode     = ModeFault;
      exp_timeout  = 1'b0;
      exp_unwanted = 1'b1;
      exp_id       = id;
      exp_addr     = '0;   // Unwanted responses carry no address
      out_meta.delete();
      out_budget.delete();
    end
    fire_check();
  endtask

  task automatic clear_faults();
    @(posedge clk);
    reset_clear <= 1'b1;
    @(posedge clk);
    reset_clear <= 1'b0;
    @(negedge clk);
    exp_mode = ModeIdle;
    fire_check();
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors != errors_at_start) begin
      failed_tests++;
      $display("test %0d %s: failed, %0d errors", tests, name, errors - errors_at_start);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
  endtask

  initial begin : watchdog
    #(WatchdogNs);
    $display("watchdog expired after %0d ns, run stopped", WatchdogNs);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    id_t   base_id;
    id_t   same_id;
    id_t   bad_id;
    id_t   to_id;
    addr_t to_addr;
    void'($urandom(32'h283d));
    aw_valid      <= 1'b0;
    aw_ready      <= 1'b0;
    aw_id         <= '0;
    aw_addr       <= '0;
    aw_len        <= '0;
    b_valid       <= 1'b0;
    b_ready       <= 1'b0;
    b_id          <= '0;
    budget_factor <= '0;
    reset_clear   <= 1'b0;
    wait (rst_n === 1'b1);
    @(posedge clk);

    begin_test();
    base_id = id_t'($urandom % 8);
    for (int i = 0; i < `GUARD_MAX_TXNS; i++) begin
      issue_write(id_t'((int'(base_id) + i) % 8), addr_t'($urandom), long_len(),
                  budget_t'(7));
    end
    for (int i = 0; i < `GUARD_MAX_TXNS; i++) begin
      send_response(id_t'((int'(base_id) + i) % 8));
    end
    end_test("in-order responses");

    begin_test();
    same_id = id_t'($urandom % 8);
    for (int i = 0; i < 4; i++) begin
      issue_write(same_id, addr_t'($urandom), long_len(), budget_t'(7));
    end
    for (int i = 0; i < 4; i++) begin
      send_response(same_id);
    end
    issue_write(same_id, addr_t'($urandom), long_len(), budget_t'(7));
    send_response(same_id);
    end_test("same-id retire order");

    // IDs from 8 up are never issued
    begin_test();
    bad_id = id_t'(8 + $urandom % 8);
    send_response(bad_id);
    clear_faults();
    end_test("unwanted response");

    begin_test();
    to_id   = id_t'($urandom % 16);
    to_addr = addr_t'($urandom);
    issue_write(to_id, to_addr, len_t'($urandom % 16), budget_t'(1));
    wait_for_fault(TimeoutWait);
    exp_mode     = ModeFault;
    exp_timeout  = 1'b1;
    exp_unwanted = 1'b0;
    exp_id       = to_id;
    exp_addr     = to_addr;
    fire_check();
    out_meta.delete();
    out_budget.delete();
    end_test("timeout");

    begin_test();
    clear_faults();
    to_id = id_t'($urandom % 16);
    issue_write(to_id, addr_t'($urandom), long_len(), budget_t'(7));
    send_response(to_id);
    end_test("clear and flush");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tick_gen.sv ====
/*
 * Countdown prescaler and the sticky B-channel activity flags
 * that hold the countdown while responses are flowing
 */
`timescale 1ns/1ns

`include "guard_consts.svh"

module tick_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic b_valid_i,
  input  logic b_ready_i,
  output logic tick_o,
  output logic pause_o
);

  localparam int unsigned PrescW = $clog2(`GUARD_PRESC_DIV);

  logic [PrescW-1:0] presc_q;
  logic              b_valid_seen_q;
  logic              b_ready_seen_q;

  assign tick_o = (presc_q == PrescW'(`GUARD_PRESC_DIV - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_q <= '0;
    end else if (tick_o) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + PrescW'(1);
    end
  end

  // Flags collect activity over one tick period and drop on the tick
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_seen_q <= 1'b0;
      b_ready_seen_q <= 1'b0;
    end else if (tick_o) begin
      b_valid_seen_q <= 1'b0;
      b_ready_seen_q <= 1'b0;
    end else begin
      b_valid_seen_q <= b_valid_seen_q | b_valid_i;
      b_ready_seen_q <= b_ready_seen_q | b_ready_i;
    end
  end

  assign pause_o = b_valid_seen_q & b_ready_seen_q;

endmodule

// ==== txn_table.sv ====
/*
 * Slot table of outstanding writes: allocation, budget countdown,
 * in-order retire per ID, timeout and unwanted-response detection, flush
 */
`timescale 1ns/1ns

`include "guard_consts.svh"

module txn_table
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  enq_if.dst   enq,
  input  logic b_valid_i,
  input  logic b_ready_i,
  input  id_t  b_id_i,
  input  logic tick_i,
  input  logic pause_i,
  input  logic flush_i,
  output cnt_t load_o,
  evt_if.src   evt
);

  localparam int unsigned NumSlots = `GUARD_MAX_TXNS;

  slot_t [NumSlots-1:0] slot_q, slot_d;
  logic  [NumSlots-1:0] live, id_hit, head_hit, expired;
  logic                 b_hs, retire, timeout, unwanted;
  slot_idx_t            retire_idx, expired_idx, free_idx, same_id_cnt;
  logic                 retire_valid_q;
  cnt_t                 retire_cnt_q;

  // Lowest set bit, used for allocation and for picking the reported slot
  function automatic slot_idx_t first_set(input logic [NumSlots-1:0] vec);
    slot_idx_t idx;
    idx = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = slot_idx_t'(i);
      end
    end
    return idx;
  endfunction

  always_comb begin
    for (int i = 0; i < NumSlots; i++) begin
      live[i]     = slot_q[i].valid;
      id_hit[i]   = live[i] && (slot_q[i].meta.id == b_id_i);
      head_hit[i] = id_hit[i] && (slot_q[i].ahead == '0);
      expired[i]  = live[i] && (slot_q[i].cnt == '0);
    end
  end

  assign b_hs        = b_valid_i & b_ready_i;
  assign retire      = b_hs & (|head_hit) & ~flush_i;
  assign timeout     = (|expired) & ~flush_i;
  assign unwanted    = b_hs & ~(|id_hit) & ~flush_i;
  assign retire_idx  = first_set(head_hit);
  assign expired_idx = first_set(expired);
  assign free_idx    = first_set(~live);

  always_comb begin
    slot_d      = slot_q;
    same_id_cnt = '0;

    // A new write queues behind every same-ID write that stays live
    for (int i = 0; i < NumSlots; i++) begin
      if (live[i] && (slot_q[i].meta.id == enq.meta.id) &&
          !(retire && (retire_idx == slot_idx_t'(i)))) begin
        same_id_cnt = same_id_cnt + slot_idx_t'(1);
      end
    end

    // Countdown holds at zero until the flush removes the slot
    if (tick_i && !pause_i) begin
      for (int i = 0; i < NumSlots; i++) begin
        if (live[i] && (slot_q[i].cnt != '0)) begin
          slot_d[i].cnt = slot_q[i].cnt - cnt_t'(1);
        end
      end
    end

    if (retire) begin
      for (int i = 0; i < NumSlots; i++) begin
        if (id_hit[i] && (retire_idx != slot_idx_t'(i))) begin
          slot_d[i].ahead = slot_q[i].ahead - slot_idx_t'(1);
        end
      end
      slot_d[retire_idx].valid = 1'b0;
    end

    // Writes beyond the slot count are dropped
    if (enq.valid && !(&live)) begin
      slot_d[free_idx].valid = 1'b1;
      slot_d[free_idx].meta  = enq.meta;
      slot_d[free_idx].cnt   = enq.budget;
      slot_d[free_idx].ahead = same_id_cnt;
    end

    if (flush_i) begin
      for (int i = 0; i < NumSlots; i++) begin
        slot_d[i].valid = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_d;
    end
  end

  // Outstanding work in prescaled ticks
  always_comb begin
    load_o = '0;
    for (int i = 0; i < NumSlots; i++) begin
      if (live[i]) begin
        load_o = load_o
               + cnt_t'((cnt_t'(slot_q[i].meta.len) + cnt_t'(1)) / `GUARD_PRESC_DIV)
               + cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      retire_cnt_q <= slot_q[retire_idx].cnt;
    end
  end

  assign evt.retire_valid = retire_valid_q;
  assign evt.retire_cnt   = retire_cnt_q;

  // Timeout has priority over an unwanted response in the same cycle
  always_comb begin
    evt.fault_valid = timeout | unwanted;
    evt.fault_kind  = FAULT_NONE;
    evt.fault_meta  = '0;
    if (timeout) begin
      evt.fault_kind = FAULT_TIMEOUT;
      evt.fault_meta = slot_q[expired_idx].meta;
    end else if (unwanted) begin
      evt.fault_kind    = FAULT_UNWANTED;
      evt.fault_meta.id = b_id_i;
    end
  end

endmodule

// ==== write_guard.sv ====
/*
 * AXI4 write transaction guard, top level
 */
`timescale 1ns/1ns

module write_guard
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    aw_valid_i,
  input  logic    aw_ready_i,
  input  id_t     aw_id_i,
  input  addr_t   aw_addr_i,
  input  len_t    aw_len_i,
  input  logic    b_valid_i,
  input  logic    b_ready_i,
  input  id_t     b_id_i,
  input  budget_t budget_factor_i,
  input  logic    reset_clear_i,
  output logic    reset_req_o,
  output logic    irq_o,
  output logic    timeout_o,
  output logic    unwanted_o,
  output addr_t   irq_addr_o,
  output id_t     irq_id_o,
  output cnt_t    latency_o
);

  aw_meta_t aw_meta;
  cnt_t     load;
  logic     tick, pause, flush;

  enq_if i_enq_if ();
  evt_if i_evt_if ();

  assign aw_meta.id   = aw_id_i;
  assign aw_meta.addr = aw_addr_i;
  assign aw_meta.len  = aw_len_i;

  aw_capture i_aw_capture (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .aw_valid_i      (aw_valid_i),
    .aw_ready_i      (aw_ready_i),
    .aw_meta_i       (aw_meta),
    .budget_factor_i (budget_factor_i),
    .load_i          (load),
    .enq             (i_enq_if.src)
  );

  tick_gen i_tick_gen (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .b_valid_i (b_valid_i),
    .b_ready_i (b_ready_i),
    .tick_o    (tick),
    .pause_o   (pause)
  );

  txn_table i_txn_table (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .enq       (i_enq_if.dst),
    .b_valid_i (b_valid_i),
    .b_ready_i (b_ready_i),
    .b_id_i    (b_id_i),
    .tick_i    (tick),
    .pause_i   (pause),
    .flush_i   (flush),
    .load_o    (load),
    .evt       (i_evt_if.src)
  );

  fault_reporter i_fault_reporter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .evt           (i_evt_if.dst),
    .reset_clear_i (reset_clear_i),
    .flush_o       (flush),
    .reset_req_o   (reset_req_o),
    .irq_o         (irq_o),
    .timeout_o     (timeout_o),
    .unwanted_o    (unwanted_o),
    .irq_addr_o    (irq_addr_o),
    .irq_id_o      (irq_id_o),
    .latency_o     (latency_o)
  );

endmodule
